/* bench/tb_memory.sv */
module tb_memory (
	input  logic                   clk,
	input  logic                   read_a,
	input  logic                   write_a,
	input  logic [3:0]             wmask_a,
	input  rv32i_types::rv32i_word address_a,
	input  rv32i_types::rv32i_word wdata_a,
	output logic                   resp_a,
	output rv32i_types::rv32i_word rdata_a,
	input  logic                   read_b,
	input  logic                   write_b,
	input  logic [3:0]             wmask_b,
	input  rv32i_types::rv32i_word address_b,
	input  rv32i_types::rv32i_word wdata_b,
	output logic                   resp_b,
	output rv32i_types::rv32i_word rdata_b
);
	timeunit 1ns;
	timeprecision 100ps;
	import rv32i_types::*;

	// 16 KB shared by fetch and data, filled by the testbench
	rv32i_word mem [4096];
	int seed;
	int wait_a, wait_b;
	logic busy_a, busy_b;

	function automatic rv32i_word merge(rv32i_word old, rv32i_word nw, logic [3:0] m);
		rv32i_word r;
		r = old;
		for (int i = 0; i < 4; i++)
			if (m[i])
				r[i*8 +: 8] = nw[i*8 +: 8];
		return r;
	endfunction

	initial begin
		seed = 3281;
		busy_a = 1'b0;
		busy_b = 1'b0;
		wait_a = 0;
		wait_b = 0;
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = '0;
		rdata_b = '0;
	end

	// Strobe is still high in the resp cycle, so that cycle never starts a request
	always @(posedge clk) begin
		resp_a <= 1'b0;
		if (resp_a) begin
			busy_a <= 1'b0;
		end else if (busy_a) begin
			if (wait_a == 0) begin
				resp_a <= 1'b1;
				if (write_a)
					mem[address_a[13:2]] <= merge(mem[address_a[13:2]], wdata_a, wmask_a);
				else
					rdata_a <= mem[address_a[13:2]];
			end else begin
				wait_a <= wait_a - 1;
			end
		end else if (read_a || write_a) begin
			busy_a <= 1'b1;
			wait_a <= $unsigned($random(seed)) % 4;
		end
	end

	always @(posedge clk) begin
		resp_b <= 1'b0;
		if (resp_b) begin
			busy_b <= 1'b0;
		end else if (busy_b) begin
			if (wait_b == 0) begin
				resp_b <= 1'b1;
				if (write_b)
					mem[address_b[13:2]] <= merge(mem[address_b[13:2]], wdata_b, wmask_b);
				else
					rdata_b <= mem[address_b[13:2]];
			end else begin
				wait_b <= wait_b - 1;
			end
		end else if (read_b || write_b) begin
			busy_b <= 1'b1;
			wait_b <= $unsigned($random(seed)) % 4;
		end
	end

endmodule : tb_memory

/* bench/tb_rv32i_pipeline.sv */
module tb_rv32i_pipeline;
	timeunit 1ns;
	timeprecision 100ps;
	import rv32i_types::*;

	localparam rv32i_word DONE_ADDR = 32'h0000_27F0;
	localparam rv32i_word JAL_SELF = 32'h0000_006F;
	localparam rv32i_word PROG_START = 32'h0000_0000;
	localparam int PROG_BODY = 200;

	logic clk, rst_n;
	logic read_a, write_a, resp_a, read_b, write_b, resp_b;
	logic [3:0] wmask_a, wmask_b;
	rv32i_word address_a, wdata_a, rdata_a, address_b, wdata_b, rdata_b;

	int seed;
	int store_idx;
	int timeout_ns;
	rv32i_word prog [$];
	rv32i_word model_mem [4096];
	rv32i_word exp_addr [$];
	rv32i_word exp_data [$];
	logic done, store_seen, fetch_seen, pending;
	rv32i_word pend_addr, pend_data;

	rv32i_pipeline dut0 (.*);
	tb_memory mem0 (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic fail_run(string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(string name, rv32i_word got, rv32i_word exp);
		if (got !== exp)
			fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_mask(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp)
			fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic int rnd(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Instruction encoders
	function automatic rv32i_word enc_i(logic [11:0] imm, rv32i_reg rs1, logic [2:0] f3,
			rv32i_reg rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_word enc_r(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
			logic [2:0] f3, rv32i_reg rd, logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_word enc_s(logic [11:0] imm, rv32i_reg rs2, rv32i_reg rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv32i_word enc_b(logic [12:0] imm, rv32i_reg rs2, rv32i_reg rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv32i_word enc_u(logic [19:0] imm, rv32i_reg rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rv32i_word enc_j(logic [20:0] imm, rv32i_reg rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Immediate extraction for the reference model
	function automatic rv32i_word imm_i(rv32i_word ins);
		return {{20{ins[31]}}, ins[31:20]};
	endfunction

	function automatic rv32i_word imm_s(rv32i_word ins);
		return {{20{ins[31]}}, ins[31:25], ins[11:7]};
	endfunction

	function automatic rv32i_word imm_b(rv32i_word ins);
		return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	endfunction

	function automatic rv32i_word imm_j(rv32i_word ins);
		return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
	endfunction

	function automatic rv32i_word alu_calc(logic [2:0] f3, logic alt, rv32i_word a,
			rv32i_word b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken(logic [2:0] f3, rv32i_word a, rv32i_word b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Background data that mixes every address bit
	function automatic rv32i_word fill_word(rv32i_word addr);
		return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
	endfunction

	task automatic emit(rv32i_word w);
		prog.push_back(w);
	endtask

	task automatic gen_alu();
		rv32i_reg rd, rs1, rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic alt;
		int kind;
		kind = rnd(8);
		rd = rv32i_reg'(2 + rnd(14));
		rs1 = rv32i_reg'(rnd(16));
		rs2 = rv32i_reg'(rnd(16));
		f3 = 3'(rnd(8));
		alt = (rnd(2) == 1);
		imm = 12'($random(seed));
		if (kind == 0) begin
			emit(enc_u(20'($random(seed)), rd, op_lui));
		end else if (kind == 1) begin
			emit(enc_u(20'($random(seed)), rd, op_auipc));
		end else if (kind < 5) begin
			if (f3 == 3'd1)
				imm = {7'b0, imm[4:0]};
			else if (f3 == 3'd5)
				imm = {1'b0, alt, 5'b0, imm[4:0]};
			emit(enc_i(imm, rs1, f3, rd, op_imm));
		end else begin
			emit(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
				rs2, rs1, f3, rd, op_reg));
		end
	endtask

	task automatic dump_regs();
		for (int r = 2; r < 16; r++)
			emit(enc_s(12'(12'h100 + 4 * r), rv32i_reg'(r), 5'd1));
	endtask

	// Forward-only control flow where every skip lands after its filler block
	task automatic build_program();
		rv32i_reg ra, rb;
		int k, sel, next_dump;
		emit(enc_u(20'h00002, 5'd1, op_lui));
		emit(enc_s(12'h000, 5'd1, 5'd1));
		next_dump = 40;
		while (prog.size() < PROG_BODY) begin
			ra = rv32i_reg'(2 + rnd(14));
			rb = rv32i_reg'(2 + rnd(14));
			k = 1 + rnd(3);
			case (rnd(12))
				5: begin
					emit(enc_i(12'(rnd(80) * 4), 5'd1, 3'b010, ra, op_load));
					emit(enc_i(12'($random(seed)), ra, 3'b000, rb, op_imm));
					emit(enc_s(12'(rnd(64) * 4), rb, 5'd1));
				end
				6: begin
					emit(enc_i(12'(rnd(80) * 4), 5'd1, 3'b010, ra, op_load));
					emit(enc_s(12'(rnd(64) * 4), ra, 5'd1));
				end
				7: emit(enc_s(12'(rnd(64) * 4), rv32i_reg'(rnd(16)), 5'd1));
				8: begin
					sel = rnd(6);
					emit(enc_b(13'((k + 1) * 4), rv32i_reg'(rnd(16)), rv32i_reg'(rnd(16)),
						3'((sel < 2) ? sel : sel + 2)));
					repeat (k) gen_alu();
				end
				9: begin
					emit(enc_j(21'((k + 1) * 4), rb));
					repeat (k) gen_alu();
				end
				10: begin
					emit(enc_u(20'h0, ra, op_auipc));
					emit(enc_i(12'(8 + 4 * k), ra, 3'b000, rb, op_jalr));
					repeat (k) gen_alu();
				end
				11: begin
					emit(enc_i(12'(rnd(80) * 4), 5'd1, 3'b010, ra, op_load));
					gen_alu();
				end
				default: gen_alu();
			endcase
			if (prog.size() >= next_dump) begin
				dump_regs();
				next_dump += 40;
			end
		end
		dump_regs();
		emit(enc_s(DONE_ADDR[11:0], 5'd2, 5'd1));
		emit(JAL_SELF);
	endtask

	// Instruction-set model that records every store in program order
	task automatic run_model();
		rv32i_word x [32];
		rv32i_word pc, ins, a, b, nxt, res, addr;
		logic wr;
		int steps;
		foreach (x[i])
			x[i] = '0;
		pc = PROG_START;
		steps = 0;
		while (model_mem[pc[13:2]] != JAL_SELF && steps < 10000) begin
			ins = model_mem[pc[13:2]];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			nxt = pc + 4;
			wr = 1'b1;
			res = '0;
			case (ins[6:0])
				7'b0110111: res = {ins[31:12], 12'h000};
				7'b0010111: res = pc + {ins[31:12], 12'h000};
				7'b1101111: begin
					res = pc + 4;
					nxt = pc + imm_j(ins);
				end
				7'b1100111: begin
					res = pc + 4;
					nxt = (a + imm_i(ins)) & ~32'd1;
				end
				7'b1100011: begin
					wr = 1'b0;
					if (taken(ins[14:12], a, b))
						nxt = pc + imm_b(ins);
				end
				7'b0000011: begin
					addr = a + imm_i(ins);
					res = model_mem[addr[13:2]];
				end
				7'b0100011: begin
					wr = 1'b0;
					addr = a + imm_s(ins);
					model_mem[addr[13:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				7'b0010011: res = alu_calc(ins[14:12], ins[14:12] == 3'd5 && ins[30], a,
					imm_i(ins));
				default: res = alu_calc(ins[14:12], ins[30], a, b);
			endcase
			if (wr && ins[11:7] != 5'd0)
				x[ins[11:7]] = res;
			pc = nxt;
			steps++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		seed = 3281;
		store_idx = 0;
		done = 1'b0;
		store_seen = 1'b0;
		fetch_seen = 1'b0;
		pending = 1'b0;
		pend_addr = '0;
		pend_data = '0;
		build_program();
		for (int i = 0; i < 4096; i++)
			model_mem[i] = fill_word(32'(i * 4));
		foreach (prog[i])
			model_mem[i] = prog[i];
		for (int i = 0; i < 4096; i++)
			mem0.mem[i] = model_mem[i];
		run_model();
		// Four cycles of worst-case latency per word with a margin of three
		timeout_ns = (prog.size() * 4 * 3 + 10) * 8;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		wait (done);
		repeat (4) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		wait (timeout_ns > 0);
		#(timeout_ns);
		fail_run("the program did not reach the done store before the timeout");
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (read_a && !fetch_seen) begin
				fetch_seen = 1'b1;
				check_word("address_a", address_a, PROG_START);
			end
			if (write_a)
				fail_run("the instruction port issued a write");
			if (write_b)
				store_seen = 1'b1;
			if (read_b && !store_seen)
				fail_run("a data read was issued before the first store");
			if (write_b) begin
				check_mask("wmask_b", wmask_b, 4'hF);
				// A waiting store must hold its request unchanged
				if (pending) begin
					check_word("address_b", address_b, pend_addr);
					check_word("wdata_b", wdata_b, pend_data);
				end
				pending = !resp_b;
				pend_addr = address_b;
				pend_data = wdata_b;
			end
			if (write_b && resp_b) begin
				if (store_idx >= exp_addr.size())
					fail_run("the DUT issued more stores than the model");
				if (address_b == DONE_ADDR && store_idx != exp_addr.size() - 1)
					fail_run("the done store came before all model stores were seen");
				check_word("address_b", address_b, exp_addr[store_idx]);
				check_word("wdata_b", wdata_b, exp_data[store_idx]);
				store_idx++;
				if (address_b == DONE_ADDR)
					done = 1'b1;
			end
		end
	end

endmodule : tb_rv32i_pipeline

/* source/alu_branch.sv */
module alu_branch (
	input  rv32i_types::rv32i_control_word ctrl,
	input  rv32i_types::rv32i_word         pc,
	input  rv32i_types::rv32i_word         rs1_out,
	input  rv32i_types::rv32i_word         rs2_out,
	input  rv32i_types::rv32i_word         mem_fwd,
	input  rv32i_types::rv32i_word         wb_fwd,
	input  logic [1:0]                     forwarding_sel1,
	input  logic [1:0]                     forwarding_sel2,
	output rv32i_types::rv32i_word         alu_out,
	output rv32i_types::rv32i_word         rs2_fwd,
	output rv32i_types::rv32i_word         jmp_pc,
	output logic                           cmp_out,
	output logic                           redirect
);
	import rv32i_types::*;

	rv32i_word rs1_fwd;
	rv32i_word a, b;
	rv32i_word cmp_b;

	always_comb begin
		case (forwarding_sel1)
			FWD_MEM: rs1_fwd = mem_fwd;
			FWD_WB:  rs1_fwd = wb_fwd;
			default: rs1_fwd = rs1_out;
		endcase
		case (forwarding_sel2)
			FWD_MEM: rs2_fwd = mem_fwd;
			FWD_WB:  rs2_fwd = wb_fwd;
			default: rs2_fwd = rs2_out;
		endcase
	end

	assign a = (ctrl.alumux1_sel == am1_pc) ? pc : rs1_fwd;

	always_comb begin
		case (ctrl.alumux2_sel)
			am2_u_imm: b = ctrl.u_imm;
			am2_b_imm: b = ctrl.b_imm;
			am2_s_imm: b = ctrl.s_imm;
			am2_j_imm: b = ctrl.j_imm;
			am2_rs2:   b = rs2_fwd;
			default:   b = ctrl.i_imm;
		endcase
	end

	always_comb begin
		case (ctrl.aluop)
			alu_sub:  alu_out = a - b;
			alu_sll:  alu_out = a << b[4:0];
			alu_slt:  alu_out = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: alu_out = {31'b0, a < b};
			alu_xor:  alu_out = a ^ b;
			alu_srl:  alu_out = a >> b[4:0];
			alu_sra:  alu_out = $signed(a) >>> b[4:0];
			alu_or:   alu_out = a | b;
			alu_and:  alu_out = a & b;
			default:  alu_out = a + b;
		endcase
	end

	assign cmp_b = (ctrl.cmpmux_sel == CMPMUX_I_IMM) ? ctrl.i_imm : rs2_fwd;

	always_comb begin
		case (ctrl.cmpop)
			beq:     cmp_out = (rs1_fwd == cmp_b);
			bne:     cmp_out = (rs1_fwd != cmp_b);
			blt:     cmp_out = ($signed(rs1_fwd) < $signed(cmp_b));
			bge:     cmp_out = ($signed(rs1_fwd) >= $signed(cmp_b));
			bltu:    cmp_out = (rs1_fwd < cmp_b);
			default: cmp_out = (rs1_fwd >= cmp_b);
		endcase
	end

	// JALR target drops bit 0
	always_comb begin
		if (ctrl.opcode == op_jalr)
			jmp_pc = (rs1_fwd + ctrl.i_imm) & ~32'd1;
		else if (ctrl.opcode == op_jal)
			jmp_pc = pc + ctrl.j_imm;
		else
			jmp_pc = pc + ctrl.b_imm;
	end

	assign redirect = ctrl.jb_sel && ((ctrl.opcode != op_br) || cmp_out);

endmodule : alu_branch

/* source/control_memory.sv */
module control_memory (
	input  rv32i_types::rv32i_word         instr,
	output rv32i_types::rv32i_control_word ctrl
);
	import rv32i_types::*;

	rv32i_opcode opcode;
	logic [2:0] funct3;
	logic funct7_5;
	logic is_slt;
	alu_ops arith_op;

	assign opcode = rv32i_opcode'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7_5 = instr[30];
	assign is_slt = (funct3 == 3'b010) || (funct3 == 3'b011);

	// Bit 30 selects sub only for register ops, sra for both forms
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
			3'b001: arith_op = alu_sll;
			3'b010: arith_op = alu_slt;
			3'b011: arith_op = alu_sltu;
			3'b100: arith_op = alu_xor;
			3'b101: arith_op = funct7_5 ? alu_sra : alu_srl;
			3'b110: arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	always_comb begin
		ctrl = BUBBLE;
		ctrl.opcode = opcode;
		ctrl.aluop = alu_add;
		ctrl.cmpop = branch_funct3'(funct3);
		ctrl.alumux1_sel = am1_rs1;
		ctrl.alumux2_sel = am2_i_imm;
		ctrl.regfilemux_sel = rf_alu_out;
		ctrl.cmpmux_sel = CMPMUX_RS2;
		ctrl.rs1 = instr[19:15];
		// rs2 stays zero unless the instruction reads it
		ctrl.rs2 = '0;
		ctrl.rd = instr[11:7];
		ctrl.i_imm = {{21{instr[31]}}, instr[30:20]};
		ctrl.s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
		ctrl.b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		ctrl.u_imm = {instr[31:12], 12'h000};
		ctrl.j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		ctrl.valid = 1'b1;
		case (opcode)
			op_lui: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = rf_u_imm;
			end
			op_auipc: begin
				ctrl.load_regfile = 1'b1;
				ctrl.alumux1_sel = am1_pc;
				ctrl.alumux2_sel = am2_u_imm;
			end
			op_jal, op_jalr: begin
				ctrl.load_regfile = 1'b1;
				ctrl.jb_sel = 1'b1;
				ctrl.regfilemux_sel = rf_pc_plus4;
			end
			op_br: begin
				ctrl.jb_sel = 1'b1;
				ctrl.rs2 = instr[24:20];
			end
			op_load: begin
				ctrl.mem_read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = rf_lw;
			end
			op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alumux2_sel = am2_s_imm;
				ctrl.rs2 = instr[24:20];
			end
			op_imm, op_reg: begin
				ctrl.load_regfile = 1'b1;
				ctrl.aluop = arith_op;
				if (opcode == op_reg) begin
					ctrl.alumux2_sel = am2_rs2;
					ctrl.rs2 = instr[24:20];
				end
				// Set-less-than results come from the comparator
				if (is_slt) begin
					ctrl.cmpop = (funct3 == 3'b010) ? blt : bltu;
					ctrl.cmpmux_sel = (opcode == op_imm) ? CMPMUX_I_IMM : CMPMUX_RS2;
					ctrl.regfilemux_sel = rf_br_en;
				end
			end
			default: ctrl = BUBBLE;
		endcase
	end

endmodule : control_memory

/* source/forwarding_unit.sv */
module forwarding_unit (
	input  rv32i_types::rv32i_reg EX_rs1,
	input  rv32i_types::rv32i_reg EX_rs2,
	input  rv32i_types::rv32i_reg MEM_rd,
	input  rv32i_types::rv32i_reg WB_rd,
	input  logic                  MEM_writeback,
	input  logic                  WB_writeback,
	input  logic                  MEM_is_load,
	input  logic                  EX_uses_rs,
	output logic [1:0]            forwarding_sel1,
	output logic [1:0]            forwarding_sel2,
	output logic                  MEM_EX_rdata_hazard
);
	import rv32i_types::*;

	logic mem_hit1, mem_hit2;
	logic wb_hit1, wb_hit2;

	assign mem_hit1 = MEM_writeback && (MEM_rd != '0) && (MEM_rd == EX_rs1);
	assign mem_hit2 = MEM_writeback && (MEM_rd != '0) && (MEM_rd == EX_rs2);
	assign wb_hit1 = WB_writeback && (WB_rd != '0) && (WB_rd == EX_rs1);
	assign wb_hit2 = WB_writeback && (WB_rd != '0) && (WB_rd == EX_rs2);

	// Younger result in MEM wins over WB
	assign forwarding_sel1 = (mem_hit1 && !MEM_is_load) ? FWD_MEM :
		wb_hit1 ? FWD_WB : FWD_REG;
	assign forwarding_sel2 = (mem_hit2 && !MEM_is_load) ? FWD_MEM :
		wb_hit2 ? FWD_WB : FWD_REG;

	// Load data is not ready until WB
	assign MEM_EX_rdata_hazard = MEM_is_load && EX_uses_rs && (mem_hit1 || mem_hit2);

endmodule : forwarding_unit

/* source/mem_access_proxy.sv */
module mem_access_proxy (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stage_read,
	input  logic                   stage_write,
	input  logic                   pipe_load,
	output logic                   mem_read,
	output logic                   mem_write,
	input  logic                   mem_resp,
	input  rv32i_types::rv32i_word mem_rdata,
	output rv32i_types::rv32i_word stage_rdata,
	output logic                   stage_resp
);
	import rv32i_types::*;

	typedef enum logic [1:0] {
		idle,
		busy,
		done
	} proxy_state_t;

	proxy_state_t state;
	rv32i_word rdata_q;
	logic request;

	assign request = stage_read | stage_write;
	// Strobe held from the first request cycle until resp
	assign mem_read = (state != done) && stage_read;
	assign mem_write = (state != done) && stage_write;
	assign stage_resp = (state == done);
	assign stage_rdata = rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (request)
						state <= mem_resp ? done : busy;
				end
				busy: begin
					if (mem_resp)
						state <= done;
				end
				default: begin
					// Wait for the pipeline to take the result
					if (pipe_load)
						state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mem_resp && state != done)
			rdata_q <= mem_rdata;
	end

endmodule : mem_access_proxy

/* source/pipe_control.sv */
module pipe_control (
	input  logic read_intr_stall,
	input  logic mem_access_stall,
	input  logic MEM_EX_rdata_hazard,
	input  logic redirect,
	output logic pc_load,
	output logic ID_load,
	output logic EX_load,
	output logic MEM_load,
	output logic WB_load,
	output logic IF_ID_flush,
	output logic MEM_flush
);

	logic stall;

	assign stall = read_intr_stall | mem_access_stall;

	always_comb begin
		pc_load = 1'b1;
		ID_load = 1'b1;
		EX_load = 1'b1;
		MEM_load = 1'b1;
		WB_load = 1'b1;
		IF_ID_flush = 1'b0;
		MEM_flush = 1'b0;
		if (stall) begin
			// Outstanding memory access freezes every stage
			pc_load = 1'b0;
			ID_load = 1'b0;
			EX_load = 1'b0;
			MEM_load = 1'b0;
			WB_load = 1'b0;
		end else if (MEM_EX_rdata_hazard) begin
			pc_load = 1'b0;
			ID_load = 1'b0;
			EX_load = 1'b0;
			MEM_flush = 1'b1;
		end else if (redirect) begin
			// Select sits in MEM, so the instruction leaving EX is wrong path too
			IF_ID_flush = 1'b1;
			MEM_flush = 1'b1;
		end
	end

endmodule : pipe_control

/* source/regfile.sv */
module regfile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  rv32i_types::rv32i_reg  rd,
	input  rv32i_types::rv32i_word wdata,
	input  rv32i_types::rv32i_reg  rs1,
	input  rv32i_types::rv32i_reg  rs2,
	output rv32i_types::rv32i_word rs1_out,
	output rv32i_types::rv32i_word rs2_out
);
	import rv32i_types::*;

	rv32i_word regs [32];
	logic bypass1, bypass2;

	// x0 is never written, so it reads as zero after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (load && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign bypass1 = load && (rd != '0) && (rd == rs1);
	assign bypass2 = load && (rd != '0) && (rd == rs2);
	assign rs1_out = bypass1 ? wdata : regs[rs1];
	assign rs2_out = bypass2 ? wdata : regs[rs2];

endmodule : regfile

/* source/rv32i_pipeline.sv */
module rv32i_pipeline (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   read_a,
	output logic                   write_a,
	output logic [3:0]             wmask_a,
	output rv32i_types::rv32i_word address_a,
	output rv32i_types::rv32i_word wdata_a,
	input  logic                   resp_a,
	input  rv32i_types::rv32i_word rdata_a,
	output logic                   read_b,
	output logic                   write_b,
	output logic [3:0]             wmask_b,
	output rv32i_types::rv32i_word address_b,
	output rv32i_types::rv32i_word wdata_b,
	input  logic                   resp_b,
	input  rv32i_types::rv32i_word rdata_b
);
	import rv32i_types::*;

	// Fetch
	rv32i_word pc;
	rv32i_word instr_rdata;
	logic instr_resp;
	logic pcmux_sel;

	// Decode
	rv32i_control_word decoded;
	rv32i_control_word ID_ctrl;
	rv32i_word ID_pc, ID_rs1_out, ID_rs2_out;

	// Execute
	rv32i_control_word EX_ctrl;
	rv32i_word EX_pc, EX_rs1_out, EX_rs2_out;
	rv32i_word EX_alu_out, EX_rs2_fwd, EX_jmp_pc;
	logic EX_cmp_out, EX_redirect, EX_uses_rs;
	logic [1:0] forwarding_sel1, forwarding_sel2;

	// Memory
	rv32i_control_word MEM_ctrl;
	rv32i_word MEM_pc, MEM_alu_out, MEM_rs2_out, MEM_jmp_pc;
	rv32i_word MEM_fwd, MEM_rdata;
	logic MEM_cmp_out, MEM_resp;

	// Writeback
	rv32i_control_word WB_ctrl;
	rv32i_word WB_pc, WB_alu_out, WB_rdata, WB_in;
	logic WB_cmp_out, wb_write;

	logic read_intr_stall, mem_access_stall, MEM_EX_rdata_hazard;
	logic pc_load, ID_load, EX_load, MEM_load, WB_load;
	logic IF_ID_flush, MEM_flush;

	assign address_a = pc;
	assign wdata_a = '0;
	assign wmask_a = 4'b0000;
	assign address_b = MEM_alu_out;
	assign wdata_b = MEM_rs2_out;
	assign wmask_b = DATA_WMASK;

	assign read_intr_stall = !instr_resp;
	assign mem_access_stall = (MEM_ctrl.mem_read | MEM_ctrl.mem_write) & !MEM_resp;
	assign EX_uses_rs = EX_ctrl.valid && (EX_ctrl.opcode != op_lui) &&
		(EX_ctrl.opcode != op_auipc) && (EX_ctrl.opcode != op_jal);
	assign wb_write = WB_load && WB_ctrl.load_regfile && (WB_ctrl.rd != '0);

	mem_access_proxy fetch_proxy (
		.clk, .rst_n,
		.stage_read(1'b1), .stage_write(1'b0), .pipe_load(ID_load),
		.mem_read(read_a), .mem_write(write_a), .mem_resp(resp_a), .mem_rdata(rdata_a),
		.stage_rdata(instr_rdata), .stage_resp(instr_resp)
	);

	mem_access_proxy data_proxy (
		.clk, .rst_n,
		.stage_read(MEM_ctrl.mem_read), .stage_write(MEM_ctrl.mem_write), .pipe_load(WB_load),
		.mem_read(read_b), .mem_write(write_b), .mem_resp(resp_b), .mem_rdata(rdata_b),
		.stage_rdata(MEM_rdata), .stage_resp(MEM_resp)
	);

	pipe_control pipe_ctrl (
		.read_intr_stall, .mem_access_stall, .MEM_EX_rdata_hazard, .redirect(pcmux_sel),
		.pc_load, .ID_load, .EX_load, .MEM_load, .WB_load, .IF_ID_flush, .MEM_flush
	);

	control_memory decoder (.instr(instr_rdata), .ctrl(decoded));

	regfile rf (
		.clk, .rst_n, .load(wb_write), .rd(WB_ctrl.rd), .wdata(WB_in),
		.rs1(ID_ctrl.rs1), .rs2(ID_ctrl.rs2), .rs1_out(ID_rs1_out), .rs2_out(ID_rs2_out)
	);

	alu_branch ex_unit (
		.ctrl(EX_ctrl), .pc(EX_pc), .rs1_out(EX_rs1_out), .rs2_out(EX_rs2_out),
		.mem_fwd(MEM_fwd), .wb_fwd(WB_in), .forwarding_sel1, .forwarding_sel2,
		.alu_out(EX_alu_out), .rs2_fwd(EX_rs2_fwd), .jmp_pc(EX_jmp_pc),
		.cmp_out(EX_cmp_out), .redirect(EX_redirect)
	);

	forwarding_unit fwd (
		.EX_rs1(EX_ctrl.rs1), .EX_rs2(EX_ctrl.rs2), .MEM_rd(MEM_ctrl.rd), .WB_rd(WB_ctrl.rd),
		.MEM_writeback(MEM_ctrl.load_regfile), .WB_writeback(WB_ctrl.load_regfile),
		.MEM_is_load(MEM_ctrl.mem_read), .EX_uses_rs,
		.forwarding_sel1, .forwarding_sel2, .MEM_EX_rdata_hazard
	);

	// Control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			ID_ctrl <= BUBBLE;
			EX_ctrl <= BUBBLE;
			MEM_ctrl <= BUBBLE;
			WB_ctrl <= BUBBLE;
			pcmux_sel <= 1'b0;
		end else begin
			if (pc_load)
				pc <= pcmux_sel ? MEM_jmp_pc : pc + 32'd4;
			if (ID_load)
				ID_ctrl <= IF_ID_flush ? BUBBLE : decoded;
			if (EX_load)
				EX_ctrl <= IF_ID_flush ? BUBBLE : ID_ctrl;
			if (MEM_load) begin
				MEM_ctrl <= MEM_flush ? BUBBLE : EX_ctrl;
				pcmux_sel <= MEM_flush ? 1'b0 : EX_redirect;
			end
			if (WB_load)
				WB_ctrl <= MEM_ctrl;
		end
	end

	// Stage payloads
	always_ff @(posedge clk) begin
		if (ID_load)
			ID_pc <= pc;
		if (EX_load) begin
			EX_pc <= ID_pc;
			EX_rs1_out <= ID_rs1_out;
			EX_rs2_out <= ID_rs2_out;
		end else if (wb_write) begin
			// Held operand picks up a writer that retires during a load-use stall
			if (WB_ctrl.rd == EX_ctrl.rs1)
				EX_rs1_out <= WB_in;
			if (WB_ctrl.rd == EX_ctrl.rs2)
				EX_rs2_out <= WB_in;
		end
		if (MEM_load) begin
			MEM_pc <= EX_pc;
			MEM_alu_out <= EX_alu_out;
			MEM_rs2_out <= EX_rs2_fwd;
			MEM_cmp_out <= EX_cmp_out;
			MEM_jmp_pc <= EX_jmp_pc;
		end
		if (WB_load) begin
			WB_pc <= MEM_pc;
			WB_alu_out <= MEM_alu_out;
			WB_cmp_out <= MEM_cmp_out;
			WB_rdata <= MEM_rdata;
		end
	end

	// Load data is never forwarded from MEM
	always_comb begin
		case (MEM_ctrl.regfilemux_sel)
			rf_br_en:    MEM_fwd = {31'b0, MEM_cmp_out};
			rf_u_imm:    MEM_fwd = MEM_ctrl.u_imm;
			rf_pc_plus4: MEM_fwd = MEM_pc + 32'd4;
			default:     MEM_fwd = MEM_alu_out;
		endcase
	end

	always_comb begin
		case (WB_ctrl.regfilemux_sel)
			rf_br_en:    WB_in = {31'b0, WB_cmp_out};
			rf_u_imm:    WB_in = WB_ctrl.u_imm;
			rf_lw:       WB_in = WB_rdata;
			rf_pc_plus4: WB_in = WB_pc + 32'd4;
			default:     WB_in = WB_alu_out;
		endcase
	end

endmodule : rv32i_pipeline

/* source/rv32i_types.sv */
package rv32i_types;

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_ops;

	// Values follow the branch funct3 field
	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3;

	typedef enum logic [2:0] {
		rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4
	} regfilemux_sel_t;

	typedef enum logic {
		am1_rs1, am1_pc
	} alumux1_sel_t;

	typedef enum logic [2:0] {
		am2_i_imm, am2_u_imm, am2_b_imm, am2_s_imm, am2_j_imm, am2_rs2
	} alumux2_sel_t;

	typedef struct packed {
		rv32i_opcode     opcode;
		alu_ops          aluop;
		branch_funct3    cmpop;
		alumux1_sel_t    alumux1_sel;
		alumux2_sel_t    alumux2_sel;
		regfilemux_sel_t regfilemux_sel;
		logic            cmpmux_sel;
		rv32i_reg        rs1;
		rv32i_reg        rs2;
		rv32i_reg        rd;
		rv32i_word       i_imm;
		rv32i_word       s_imm;
		rv32i_word       b_imm;
		rv32i_word       u_imm;
		rv32i_word       j_imm;
		logic            mem_read;
		logic            mem_write;
		logic            load_regfile;
		logic            jb_sel;
		logic            valid;
	} rv32i_control_word;

	localparam rv32i_word RESET_PC = 32'h0000_0000;
	localparam logic [3:0] DATA_WMASK = 4'b1111;
	localparam rv32i_control_word BUBBLE = '0;

	// Comparator second operand
	localparam logic CMPMUX_RS2 = 1'b0;
	localparam logic CMPMUX_I_IMM = 1'b1;

	// Operand sources in EX
	localparam logic [1:0] FWD_REG = 2'b00;
	localparam logic [1:0] FWD_MEM = 2'b01;
	localparam logic [1:0] FWD_WB = 2'b10;

endpackage : rv32i_types

/* sources.f */
source/rv32i_types.sv
source/control_memory.sv
source/regfile.sv
source/alu_branch.sv
source/forwarding_unit.sv
source/mem_access_proxy.sv
source/pipe_control.sv
source/rv32i_pipeline.sv
bench/tb_memory.sv
bench/tb_rv32i_pipeline.sv
